//--- verilog.f
+incdir+include
design/eth_pkt_pkg.sv
design/byte_to_word.sv
design/pkt_classifier.sv
design/ctrl_cmd_engine.sv
design/pkt_poll_mux.sv
design/word_to_byte.sv
design/ctrl_loop_top.sv
sim/tb_ctrl_loop.sv

//--- run.sh
#!/bin/sh
# build the packet loop testbench with Verilator, run it, judge the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module tb_ctrl_loop \
	&& ./obj_dir/Vtb_ctrl_loop | tee sim.log \
	&& ! grep -q "Test FAILED" sim.log \
	&& grep -q "Test OK" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

//--- include/tb_ref_model.svh
/*
 * tb_ref_model
 * reply reference model, rx packet drivers and the expected-packet
 * queues of the packet loop testbench, included inside tb_ctrl_loop
 */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

reg_val_t   model_regs [REG_COUNT];        // bank as the model sees it
logic [7:0] pkt_buf [64];                  // packet being driven
logic [7:0] exp_data [$];                  // data packets, back to back
int         exp_len [$];                   // byte count per data packet
word_t      exp_reply [$];                 // one word per reply
int         n_data_tx;

// ----------------------------------------------------------------------
// reply model
// ----------------------------------------------------------------------
function automatic word_t ref_reply(input logic [7:0] op, input reg_idx_t idx,
		input reg_val_t val);
	word_t w;
	w       = '0;                          // bytes 6 and 7 stay zero
	w[15:8] = {5'b00000, idx};
	if (op == OP_WRITE)
		model_regs[idx] = val;             // write lands before the reply
	if (op == OP_READ || op == OP_WRITE) begin
		w[7:0]   = op | 8'h80;
		w[47:16] = model_regs[idx];        // value after the op, lsb in byte 2
	end else
		w[7:0] = 8'hFF;                    // unknown opcode, value zero
	return w;
endfunction

// ----------------------------------------------------------------------
// rx drivers, one byte per cycle on the falling edge
// ----------------------------------------------------------------------
task automatic drive_packet(input int len);
	for (int i = 0; i < len; i++) begin
		@(negedge i_sys_clk);
		i_rx_data  = pkt_buf[i];
		i_rx_valid = 1'b1;
		i_rx_last  = (i == len - 1);
	end
	@(negedge i_sys_clk);
	i_rx_valid = 1'b0;                     // at least one idle cycle
	i_rx_last  = 1'b0;
endtask

task automatic idle(input int n);
	repeat (n) @(negedge i_sys_clk);
endtask

task automatic send_data_pkt(input int len);
	pkt_buf[0] = 8'h02;                    // unicast, never the chip MAC
	pkt_buf[1] = 8'(n_data_tx);            // sequence tag
	for (int i = 2; i < len; i++)
		pkt_buf[i] = 8'($urandom);
	for (int i = 0; i < len; i++)
		exp_data.push_back(pkt_buf[i]);
	exp_len.push_back(len);
	n_data_tx++;
	drive_packet(len);
endtask

// two words: chip MAC + pad, then opcode, index, value
task automatic send_ctrl_pkt(input logic [7:0] op, input reg_idx_t idx, input reg_val_t val);
	logic [7:0] pad;
	pad = 8'($urandom);
	for (int i = 0; i < 6; i++)
		pkt_buf[i] = CHIP_MAC[47 - 8*i -: 8];  // byte 0 is the msb
	pkt_buf[6] = pad;
	pkt_buf[7] = ~pad;
	pkt_buf[8] = op;
	pkt_buf[9] = {pad[4:0], idx};          // high bits must be ignored
	for (int i = 0; i < 4; i++)
		pkt_buf[10 + i] = val[8*i +: 8];
	pkt_buf[14] = pad ^ 8'h5A;
	pkt_buf[15] = 8'h00;
	exp_reply.push_back(ref_reply(op, idx, val));
	drive_packet(16);
endtask

`endif

//--- sim/tb_ctrl_loop.sv
/*
 * tb_ctrl_loop
 * drives rx packets into the packet loop and checks every tx packet
 * against the reply model and the queue of sent data packets
 */
module tb_ctrl_loop;
	import eth_pkt_pkg::*;

	localparam int          MAX_CYCLES = 20000;
	localparam logic [31:0] SEED       = 32'h2722_02b3;

	logic        i_sys_clk, i_rst_n;
	logic [7:0]  i_rx_data;
	logic        i_rx_valid, i_rx_last, i_tx_ready;
	logic [7:0]  o_tx_data;
	logic        o_tx_valid, o_tx_last;
	logic [15:0] o_drop_cnt;

	logic [7:0]  got [$];                   // bytes of the packet on the tx port
	int          errors, n_rx, n_data_rx, rx_base, drop_base;
	int          cycles = 0;
	logic        skip_ok;                   // drops allowed while the FIFO backs up

	`include "tb_ref_model.svh"

	ctrl_loop_top UUT (.*);

	initial begin
		i_sys_clk = 1'b0;
		forever #4 i_sys_clk = ~i_sys_clk;
	end

	always @(posedge i_sys_clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout after %0d cycles, output did not drain", cycles);
			$display("Test FAILED");
			$finish;
		end
	end

	// ----------------------------------------------------------------------
	// output monitor and compare
	// ----------------------------------------------------------------------
	task automatic check_packet();
		word_t w;
		int    len;
		logic  same;
		n_rx++;
		if (got[0][7]) begin                   // reply opcodes carry bit 7
			if (exp_reply.size() == 0) begin
				$display("%0t: reply packet arrived with no command pending", $time);
				errors++;
				return;
			end
			w = exp_reply.pop_front();
			if (got.size() != 8) begin
				$display("ERROR %0t o_tx_last reply length: expected 8, got %0d",
					$time, got.size());
				errors++;
			end
			for (int i = 0; i < 8; i++)
				if (got[i] !== w[8*i +: 8]) begin
					$display("ERROR %0t o_tx_data reply byte %0d: expected %h, got %h",
						$time, i, w[8*i +: 8], got[i]);
					errors++;
				end
			return;
		end
		n_data_rx++;
		same = 1'b0;
		while (!same && exp_len.size() > 0) begin
			len  = exp_len[0];
			same = (len == got.size());
			for (int i = 0; i < len && same; i++)
				same = (exp_data[i] === got[i]);
			if (!same && !skip_ok)
				break;
			if (!same) begin                   // skip a packet dropped upstream
				repeat (len) void'(exp_data.pop_front());
				void'(exp_len.pop_front());
			end
		end
		if (exp_len.size() == 0) begin
			$display("%0t: data packet of %0d bytes matches no sent packet",
				$time, got.size());
			errors++;
			return;
		end
		if (got.size() != len) begin
			$display("ERROR %0t o_tx_last data length: expected %0d, got %0d",
				$time, len, got.size());
			errors++;
		end
		for (int i = 0; i < len && i < got.size(); i++)
			if (got[i] !== exp_data[i]) begin
				$display("ERROR %0t o_tx_data data byte %0d: expected %h, got %h",
					$time, i, exp_data[i], got[i]);
				errors++;
			end
		repeat (len) void'(exp_data.pop_front());
		void'(exp_len.pop_front());
	endtask

	always @(posedge i_sys_clk) begin
		if (i_rst_n && o_tx_valid && i_tx_ready) begin
			got.push_back(o_tx_data);
			if (o_tx_last) begin
				check_packet();
				got.delete();
			end
		end
	end

	task automatic wait_drained();
		while (exp_len.size() != 0 || exp_reply.size() != 0)
			@(posedge i_sys_clk);
	endtask

	// ----------------------------------------------------------------------
	// stimulus
	// ----------------------------------------------------------------------
	initial begin
		int pick;
		i_rst_n    = 1'b0;
		i_rx_data  = '0;
		i_rx_valid = 1'b0;
		i_rx_last  = 1'b0;
		i_tx_ready = 1'b1;
		errors     = 0;
		n_rx       = 0;
		n_data_rx  = 0;
		n_data_tx  = 0;
		skip_ok    = 1'b0;
		void'($urandom(SEED));
		for (int i = 0; i < REG_COUNT; i++)
			model_regs[i] = '0;
		repeat (4) @(negedge i_sys_clk);
		i_rst_n = 1'b1;
		idle(4);

		// plain data stream with ready always high
		repeat (100) begin
			send_data_pkt(1 + $urandom_range(39));
			idle($urandom_range(3));
		end
		wait_drained();

		// write and read back, an unwritten register, then an unknown opcode
		send_ctrl_pkt(OP_WRITE, 3'd3, 32'hDEAD_BEEF);
		idle(20);
		send_ctrl_pkt(OP_READ, 3'd3, 32'h0);
		idle(20);
		send_ctrl_pkt(OP_READ, 3'd6, $urandom);
		idle(20);
		for (int i = 0; i < REG_COUNT; i += 2) begin
			send_ctrl_pkt(OP_WRITE, 3'(i), $urandom);
			idle(20);
			send_ctrl_pkt(OP_READ, 3'(i), $urandom);
			idle(20);
		end
		send_ctrl_pkt(8'h33, 3'd3, 32'h1234_5678);
		idle(20);
		send_ctrl_pkt(OP_READ, 3'd3, 32'h0);
		idle(20);
		wait_drained();

		// control and data mixed with 20+ idle cycles between packets
		repeat (40) begin
			pick = $urandom_range(3);
			if (pick == 0)
				send_data_pkt(1 + $urandom_range(39));
			else
				send_ctrl_pkt(pick == 3 ? 8'h5A : 8'(pick), 3'($urandom), $urandom);
			idle(20 + $urandom_range(10));
		end
		wait_drained();

		// back-pressure with ready low for 300 cycles
		rx_base   = n_data_rx;
		drop_base = int'(o_drop_cnt);
		skip_ok   = 1'b1;
		idle(1);
		fork
			begin
				i_tx_ready = 1'b0;
				idle(300);
				i_tx_ready = 1'b1;
			end
			repeat (30) begin
				send_data_pkt(8 + $urandom_range(32));
				idle(2 + $urandom_range(3));
			end
		join
		while (n_data_rx - rx_base + int'(o_drop_cnt) - drop_base < 30)
			@(posedge i_sys_clk);
		idle(50);
		if (n_data_rx - rx_base + int'(o_drop_cnt) - drop_base != 30) begin
			$display("%0t: received plus dropped does not add up to 30 sent", $time);
			errors++;
		end
		if (int'(o_drop_cnt) == drop_base) begin
			$display("%0t: back-pressure phase dropped no packet", $time);
			errors++;
		end
		skip_ok = 1'b0;
		exp_data.delete();
		exp_len.delete();

		idle(10);
		$display("checked %0d packets, %0d data sent, %0d dropped, %0d errors",
			n_rx, n_data_tx, o_drop_cnt, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

//--- design/ctrl_loop_top.sv
/*
 * ctrl_loop_top
 * rx bytes -> words -> classifier -> data path / control engine
 * -> poll mux -> serializer -> tx bytes, all on i_sys_clk
 */
module ctrl_loop_top (
	input  logic                             i_sys_clk,
	input  logic                             i_rst_n,
	input  logic [eth_pkt_pkg::BYTE_W-1:0]   i_rx_data,
	input  logic                             i_rx_valid,
	input  logic                             i_rx_last,
	input  logic                             i_tx_ready,
	output logic [eth_pkt_pkg::BYTE_W-1:0]   o_tx_data,
	output logic                             o_tx_valid,
	output logic                             o_tx_last,
	output logic [15:0]                      o_drop_cnt
);
	import eth_pkt_pkg::*;

	// ----------------------------------------------------------------------
	// word links
	// ----------------------------------------------------------------------
	word_t  rx_word;                                       // from byte_to_word
	logic   rx_valid, rx_sop, rx_eop;
	empty_t rx_empty;
	word_t  dp_word;                                       // data path
	logic   dp_valid, dp_sop, dp_eop;
	empty_t dp_empty;
	word_t  cp_word;                                       // control path
	logic   cp_valid, cp_sop, cp_eop;
	word_t  tx_word;                                       // merged stream
	logic   tx_valid, tx_sop, tx_eop;
	empty_t tx_empty;
	word_t  reply_word;
	logic   reply_valid, reply_taken, ctrl_busy;
	logic   fifo_alf, data_alf;                            // serializer level via the mux

	byte_to_word u_b2w (
		.i_sys_clk (i_sys_clk),  .i_rst_n (i_rst_n),
		.i_rx_data (i_rx_data),  .i_rx_valid (i_rx_valid), .i_rx_last (i_rx_last),
		.o_word (rx_word), .o_valid (rx_valid), .o_sop (rx_sop), .o_eop (rx_eop),
		.o_empty (rx_empty)
	);

	pkt_classifier u_cls (
		.i_sys_clk (i_sys_clk),  .i_rst_n (i_rst_n),
		.i_word (rx_word), .i_valid (rx_valid), .i_sop (rx_sop), .i_eop (rx_eop),
		.i_empty (rx_empty), .i_data_alf (data_alf), .i_ctrl_busy (ctrl_busy),
		.o_data_word (dp_word), .o_data_valid (dp_valid), .o_data_sop (dp_sop),
		.o_data_eop (dp_eop),   .o_data_empty (dp_empty),
		.o_ctrl_word (cp_word), .o_ctrl_valid (cp_valid), .o_ctrl_sop (cp_sop),
		.o_ctrl_eop (cp_eop),   .o_drop_cnt (o_drop_cnt)
	);

	ctrl_cmd_engine u_eng (
		.i_sys_clk (i_sys_clk),  .i_rst_n (i_rst_n),
		.i_word (cp_word), .i_valid (cp_valid), .i_sop (cp_sop), .i_eop (cp_eop),
		.i_reply_taken (reply_taken), .o_busy (ctrl_busy),
		.o_reply_valid (reply_valid), .o_reply_word (reply_word)
	);

	pkt_poll_mux u_mux (
		.i_sys_clk (i_sys_clk),  .i_rst_n (i_rst_n),
		.i_word (dp_word), .i_valid (dp_valid), .i_sop (dp_sop), .i_eop (dp_eop),
		.i_empty (dp_empty), .i_reply_valid (reply_valid), .i_reply_word (reply_word),
		.i_fifo_alf (fifo_alf), .o_reply_taken (reply_taken),
		.o_word (tx_word), .o_valid (tx_valid), .o_sop (tx_sop), .o_eop (tx_eop),
		.o_empty (tx_empty), .o_data_alf (data_alf)
	);

	word_to_byte u_w2b (
		.i_sys_clk (i_sys_clk),  .i_rst_n (i_rst_n),
		.i_word (tx_word), .i_valid (tx_valid), .i_sop (tx_sop), .i_eop (tx_eop),
		.i_empty (tx_empty), .i_tx_ready (i_tx_ready),
		.o_tx_data (o_tx_data), .o_tx_valid (o_tx_valid), .o_tx_last (o_tx_last),
		.o_fifo_alf (fifo_alf)
	);

endmodule

//--- design/word_to_byte.sv
/*
 * word_to_byte
 * word FIFO in front of a byte serializer, lane 0 first, stops at the
 * last valid byte of an eop word and flags almost full
 */
module word_to_byte (
	input  logic                             i_sys_clk,
	input  logic                             i_rst_n,
	input  eth_pkt_pkg::word_t               i_word,
	input  logic                             i_valid,
	input  logic                             i_sop,
	input  logic                             i_eop,
	input  eth_pkt_pkg::empty_t              i_empty,
	input  logic                             i_tx_ready,
	output logic [eth_pkt_pkg::BYTE_W-1:0]   o_tx_data,
	output logic                             o_tx_valid,
	output logic                             o_tx_last,
	output logic                             o_fifo_alf
);
	import eth_pkt_pkg::*;

	word_t  mem_word  [FIFO_DEPTH];
	logic   mem_eop   [FIFO_DEPTH];
	empty_t mem_empty [FIFO_DEPTH];

	logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr, rd_ptr;
	logic [$clog2(FIFO_DEPTH):0]   count;      // words held
	logic [2:0] lane;                           // byte on the tx port
	logic [2:0] last_lane;                      // final lane of the head word
	logic       at_end, pop, in_pkt;

	// ----------------------------------------------------------------------
	// serializer side
	// ----------------------------------------------------------------------
	assign o_tx_valid = (count != '0);
	assign last_lane  = mem_eop[rd_ptr] ? 3'(WORD_BYTES - 1) - mem_empty[rd_ptr] : 3'd7;
	assign at_end     = (lane == last_lane);
	assign o_tx_data  = mem_word[rd_ptr][lane*BYTE_W +: BYTE_W];
	assign o_tx_last  = o_tx_valid && mem_eop[rd_ptr] && at_end;
	assign pop        = o_tx_valid && i_tx_ready && at_end;   // head word drained
	assign o_fifo_alf = (count >= FIFO_ALF);

	always_ff @(posedge i_sys_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			lane   <= '0;
			in_pkt <= 1'b0;
		end else begin
			if (i_valid) begin
				wr_ptr <= wr_ptr + 1'b1;
				in_pkt <= !i_eop;
			end
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (i_valid && !pop)
				count <= count + 1'b1;
			else if (!i_valid && pop)
				count <= count - 1'b1;
			if (o_tx_valid && i_tx_ready)
				lane <= at_end ? 3'd0 : lane + 3'd1;     // byte held while not ready
		end
	end

	always_ff @(posedge i_sys_clk) begin
		if (i_valid) begin
			mem_word[wr_ptr]  <= i_word;
			mem_eop[wr_ptr]   <= i_eop;
			mem_empty[wr_ptr] <= i_empty;
		end
	end

	// the almost-full margin upstream must cover every in-flight tail
	a_no_overflow: assert property (
		@(posedge i_sys_clk) disable iff (!i_rst_n)
		i_valid |-> (count < FIFO_DEPTH)
	);

	// merged stream stays framed, a new packet always opens with sop
	a_sop_framing: assert property (
		@(posedge i_sys_clk) disable iff (!i_rst_n)
		(i_valid && !in_pkt) |-> i_sop
	);

endmodule

//--- design/pkt_poll_mux.sv
/*
 * pkt_poll_mux
 * merges data packets and single-word replies at packet boundaries,
 * data never stalls and owns the next packet after a reply
 */
module pkt_poll_mux (
	input  logic                  i_sys_clk,
	input  logic                  i_rst_n,
	input  eth_pkt_pkg::word_t    i_word,
	input  logic                  i_valid,
	input  logic                  i_sop,
	input  logic                  i_eop,
	input  eth_pkt_pkg::empty_t   i_empty,
	input  logic                  i_reply_valid,
	input  eth_pkt_pkg::word_t    i_reply_word,
	input  logic                  i_fifo_alf,
	output logic                  o_reply_taken,
	output eth_pkt_pkg::word_t    o_word,
	output logic                  o_valid,
	output logic                  o_sop,
	output logic                  o_eop,
	output eth_pkt_pkg::empty_t   o_empty,
	output logic                  o_data_alf
);
	import eth_pkt_pkg::*;

	pkt_state_e state;                      // FWD while a data packet is open
	logic       data_turn;                  // data owns the boundary after a reply
	logic       send_reply;

	// reply only in a hole, never inside a data packet
	assign send_reply = i_reply_valid && !i_valid && (state == IDLE) && !data_turn;
	assign o_data_alf = i_fifo_alf;         // serializer level back to classifier

	always_ff @(posedge i_sys_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state         <= IDLE;
			data_turn     <= 1'b0;
			o_reply_taken <= 1'b0;
			o_valid       <= 1'b0;
			o_sop         <= 1'b0;
			o_eop         <= 1'b0;
		end else begin
			o_valid       <= i_valid || send_reply;
			o_sop         <= i_valid ? i_sop : send_reply;   // reply is sop and eop
			o_eop         <= i_valid ? i_eop : send_reply;
			o_reply_taken <= send_reply;                     // one-cycle pulse
			if (i_valid)
				state <= i_eop ? IDLE : FWD;
			if (send_reply)
				data_turn <= 1'b1;
			else if ((i_valid && i_eop) || (!i_valid && state == IDLE))
				data_turn <= 1'b0;                           // data packet done or idle
		end
	end

	always_ff @(posedge i_sys_clk) begin
		if (i_valid) begin
			o_word  <= i_word;
			o_empty <= i_empty;
		end else if (send_reply) begin
			o_word  <= i_reply_word;
			o_empty <= '0;                                   // full word
		end
	end

endmodule

//--- design/ctrl_cmd_engine.sv
/*
 * ctrl_cmd_engine
 * runs register read / write commands from control packets against
 * an 8 x 32 register bank and holds a one-word reply until taken
 */
module ctrl_cmd_engine (
	input  logic                  i_sys_clk,
	input  logic                  i_rst_n,
	input  eth_pkt_pkg::word_t    i_word,
	input  logic                  i_valid,
	input  logic                  i_sop,
	input  logic                  i_eop,
	input  logic                  i_reply_taken,
	output logic                  o_busy,
	output logic                  o_reply_valid,
	output eth_pkt_pkg::word_t    o_reply_word
);
	import eth_pkt_pkg::*;

	reg_val_t   regs [REG_COUNT];
	logic [1:0] wcnt;                       // words seen, stops at 2
	word_t      cmd_q;                      // second word, packet longer than 2
	word_t      cmd;                        // command word used at eop
	opcode_e    op;
	reg_idx_t   idx;
	reg_val_t   wr_val;
	logic [7:0] rep_op;
	reg_val_t   rep_val;                    // register value after the op
	logic       exec;

	// ----------------------------------------------------------------------
	// command decode
	// ----------------------------------------------------------------------
	assign cmd    = (wcnt == 2'd1) ? i_word : cmd_q;   // eop on word 2 or later
	assign op     = opcode_e'(cmd[7:0]);
	assign idx    = cmd[10:8];                          // low 3 bits of byte 1
	assign wr_val = cmd[47:16];                         // bytes 2..5, little endian
	assign exec   = i_valid && i_eop && !i_sop && (wcnt != 2'd0);

	always_comb begin
		case (op)
			OP_READ: begin
				rep_op  = cmd[7:0] | REPLY_FLAG;
				rep_val = regs[idx];
			end
			OP_WRITE: begin
				rep_op  = cmd[7:0] | REPLY_FLAG;
				rep_val = wr_val;                           // value as written
			end
			default: begin
				rep_op  = REPLY_BAD;
				rep_val = '0;
			end
		endcase
	end

	assign o_busy = o_reply_valid;          // one reply outstanding at most

	// ----------------------------------------------------------------------
	// register bank and reply hold
	// ----------------------------------------------------------------------
	always_ff @(posedge i_sys_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			wcnt          <= '0;
			o_reply_valid <= 1'b0;
			for (int i = 0; i < REG_COUNT; i++)
				regs[i] <= '0;
		end else begin
			if (i_valid) begin
				if (i_eop)
					wcnt <= 2'd0;
				else if (i_sop)
					wcnt <= 2'd1;
				else if (wcnt == 2'd1)
					wcnt <= 2'd2;
			end
			if (exec && op == OP_WRITE)
				regs[idx] <= wr_val;                        // same edge as reply
			if (exec)
				o_reply_valid <= 1'b1;
			else if (i_reply_taken)
				o_reply_valid <= 1'b0;
		end
	end

	always_ff @(posedge i_sys_clk) begin
		if (i_valid && !i_sop && wcnt == 2'd1)
			cmd_q <= i_word;
		if (exec)
			o_reply_word <= {16'h0000, rep_val, 5'b00000, idx, rep_op};
	end

	// the mux only takes a reply that is actually held
	a_taken_while_valid: assert property (
		@(posedge i_sys_clk) disable iff (!i_rst_n)
		i_reply_taken |-> o_reply_valid
	);

endmodule

//--- design/pkt_classifier.sv
/*
 * pkt_classifier
 * steers each packet to the control or data path by destination MAC,
 * drops whole packets whose path is blocked at sop and counts them
 */
module pkt_classifier (
	input  logic                  i_sys_clk,
	input  logic                  i_rst_n,
	input  eth_pkt_pkg::word_t    i_word,
	input  logic                  i_valid,
	input  logic                  i_sop,
	input  logic                  i_eop,
	input  eth_pkt_pkg::empty_t   i_empty,
	input  logic                  i_data_alf,
	input  logic                  i_ctrl_busy,
	output eth_pkt_pkg::word_t    o_data_word,
	output logic                  o_data_valid,
	output logic                  o_data_sop,
	output logic                  o_data_eop,
	output eth_pkt_pkg::empty_t   o_data_empty,
	output eth_pkt_pkg::word_t    o_ctrl_word,
	output logic                  o_ctrl_valid,
	output logic                  o_ctrl_sop,
	output logic                  o_ctrl_eop,
	output logic [15:0]           o_drop_cnt
);
	import eth_pkt_pkg::*;

	pkt_state_e state;
	logic       to_ctrl;                    // path latched at sop
	mac_t       dst_mac;
	logic       is_ctrl, blocked, path_ctrl, pass;

	always_comb begin
		for (int i = 0; i < 6; i++)
			dst_mac[47 - i*BYTE_W -: BYTE_W] = i_word[i*BYTE_W +: BYTE_W];  // byte 0 is msb
	end

	assign is_ctrl   = (dst_mac == CHIP_MAC);
	assign blocked   = is_ctrl ? i_ctrl_busy : i_data_alf;   // reply pending / FIFO filling
	assign path_ctrl = i_sop ? is_ctrl : to_ctrl;
	assign pass      = i_valid && (i_sop ? !blocked : (state == FWD));

	always_ff @(posedge i_sys_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state        <= IDLE;
			to_ctrl      <= 1'b0;
			o_drop_cnt   <= '0;
			o_data_valid <= 1'b0;
			o_data_sop   <= 1'b0;
			o_data_eop   <= 1'b0;
			o_ctrl_valid <= 1'b0;
			o_ctrl_sop   <= 1'b0;
			o_ctrl_eop   <= 1'b0;
		end else begin
			o_data_valid <= pass && !path_ctrl;
			o_data_sop   <= pass && !path_ctrl && i_sop;
			o_data_eop   <= pass && !path_ctrl && i_eop;
			o_ctrl_valid <= pass && path_ctrl;
			o_ctrl_sop   <= pass && path_ctrl && i_sop;
			o_ctrl_eop   <= pass && path_ctrl && i_eop;
			if (i_valid && i_sop) begin
				to_ctrl <= is_ctrl;
				if (blocked)
					o_drop_cnt <= o_drop_cnt + 16'd1;   // whole packet goes
			end
			if (i_valid) begin
				if (i_eop)
					state <= IDLE;
				else if (i_sop)
					state <= blocked ? DROP : FWD;      // held until eop
			end
		end
	end

	always_ff @(posedge i_sys_clk) begin
		if (i_valid) begin
			o_data_word  <= i_word;
			o_data_empty <= i_empty;
			o_ctrl_word  <= i_word;
		end
	end

	// a dropped packet stays dropped up to its eop
	a_no_fwd_in_drop: assert property (
		@(posedge i_sys_clk) disable iff (!i_rst_n)
		(state == DROP) |=> !(o_data_valid || o_ctrl_valid)
	);

endmodule

//--- design/byte_to_word.sv
/*
 * byte_to_word
 * packs the received byte stream into 64-bit words, lane 0 first,
 * and marks start, end and the unused byte count of the last word
 */
module byte_to_word (
	input  logic                             i_sys_clk,
	input  logic                             i_rst_n,
	input  logic [eth_pkt_pkg::BYTE_W-1:0]   i_rx_data,
	input  logic                             i_rx_valid,
	input  logic                             i_rx_last,
	output eth_pkt_pkg::word_t               o_word,
	output logic                             o_valid,
	output logic                             o_sop,
	output logic                             o_eop,
	output eth_pkt_pkg::empty_t              o_empty
);
	import eth_pkt_pkg::*;

	logic [2:0] lane;                       // next lane to fill
	logic       first;                      // next word opens a packet
	word_t      acc;                        // word under assembly
	word_t      nxt_word;                   // acc with this byte merged in
	logic       word_done;                  // 8th byte or last byte

	always_comb begin
		nxt_word = (lane == 3'd0) ? '0 : acc;   // fresh word, clear stale lanes
		nxt_word[lane*BYTE_W +: BYTE_W] = i_rx_data;
	end

	assign word_done = i_rx_valid && (i_rx_last || lane == 3'(WORD_BYTES - 1));

	always_ff @(posedge i_sys_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			lane    <= '0;
			first   <= 1'b1;
			o_valid <= 1'b0;
			o_sop   <= 1'b0;
			o_eop   <= 1'b0;
			o_empty <= '0;
		end else begin
			o_valid <= word_done;
			o_sop   <= word_done && first;
			o_eop   <= word_done && i_rx_last;
			if (word_done) begin
				o_empty <= empty_t'(WORD_BYTES - 1) - lane;   // 0 for a full word
				first   <= i_rx_last;                          // re-arm after packet end
			end
			if (i_rx_valid)
				lane <= i_rx_last ? 3'd0 : lane + 3'd1;       // wraps after lane 7
		end
	end

	// payload, no reset
	always_ff @(posedge i_sys_clk) begin
		if (i_rx_valid)
			acc <= nxt_word;
		if (word_done)
			o_word <= nxt_word;
	end

	// framing flags only ride on a valid word
	a_flags_need_valid: assert property (
		@(posedge i_sys_clk) disable iff (!i_rst_n)
		(o_sop || o_eop) |-> o_valid
	);

endmodule

//--- design/eth_pkt_pkg.sv
/*
 * eth_pkt_pkg
 * shared widths, the chip MAC, register bank size, serializer FIFO
 * limits and the opcode / packet state enums of the packet loop
 */
package eth_pkt_pkg;

	// ----------------------------------------------------------------------
	// word link
	// ----------------------------------------------------------------------
	localparam int BYTE_W     = 8;                         // one byte lane
	localparam int WORD_BYTES = 8;                         // lanes per word

	typedef logic [BYTE_W*WORD_BYTES-1:0] word_t;          // byte 0 in [7:0]
	typedef logic [2:0]                   empty_t;         // unused high bytes, last word

	// ----------------------------------------------------------------------
	// control path
	// ----------------------------------------------------------------------
	typedef logic [47:0] mac_t;
	localparam mac_t CHIP_MAC = 48'h888888888888;          // byte 0 is the msb

	localparam int REG_COUNT = 8;
	typedef logic [2:0]  reg_idx_t;
	typedef logic [31:0] reg_val_t;

	typedef enum logic [7:0] {
		OP_READ  = 8'd1,
		OP_WRITE = 8'd2
	} opcode_e;

	localparam logic [7:0] REPLY_FLAG = 8'h80;             // or'ed into a good opcode
	localparam logic [7:0] REPLY_BAD  = 8'hFF;             // unknown opcode

	// serializer FIFO, in words
	localparam int FIFO_DEPTH = 16;
	localparam int FIFO_ALF   = 12;                        // 4 words of margin

	typedef enum logic [1:0] {
		IDLE,
		FWD,
		DROP
	} pkt_state_e;

endpackage
